//--- files.f
+incdir+design
design/ex_issue_pkg.sv
design/ex_result_pkg.sv
design/ex_operand_mux.sv
design/ex_skid_fifo.sv
design/ex_mul_iter.sv
design/ex_alu.sv
design/ex_unit.sv
dv/ex_unit_checker.sv
dv/ex_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module ex_unit_tb -f files.f -o ex_unit_sim
./obj_dir/ex_unit_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi

//--- dv/ex_unit_tb.sv
`include "ex_defs.svh"

module ex_unit_tb;
    import ex_issue_pkg::*;
    import ex_result_pkg::*;

    typedef struct packed {
        ex_issue_t req;
        logic      rand_ready;
        logic      flush_after;
    } row_t;

    localparam logic [63:0] smin = 64'h8000_0000_0000_0000;

    logic        clk = 1'b0;
    logic        rst;
    logic        flush;
    logic        req_valid;
    logic        req_ready;
    ex_issue_t   req;
    logic        res_valid;
    logic        res_ready;
    ex_result_t  res;

    row_t        rows[$];
    ex_result_t  exp_q[$];
    int          row_q[$];
    logic [31:0] rng = 32'hef27_e36a;
    int          passed = 0;
    int          errors = 0;
    int          dropped = 0;

    ex_unit dut_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function logic [63:0] rand64();
        rng = xorshift(rng);
        rand64[63:32] = rng;
        rng = xorshift(rng);
        rand64[31:0] = rng;
    endfunction

    // expected value built from the execute-stage rules
    function automatic ex_result_t expected_result(input ex_issue_t r);
        logic [63:0]        a;
        logic [63:0]        b;
        logic [63:0]        v;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] sh;
        logic signed [63:0] wsh;
        logic signed [63:0] q;
        logic signed [63:0] m;
        logic               ovf;
        ex_result_t         res_exp;
        a = (r.src_a == src_a_pc) ? r.pc : r.word ? {32'b0, r.rs1[31:0]} : r.rs1;
        b = (r.src_b == src_b_rs2) ? r.rs2 : (r.src_b == src_b_csr) ? r.csr : r.imm;
        sa  = a;
        sb  = b;
        sh  = sa >>> b[5:0];
        // word sra shifts the sign-extended low half, keeps 32 bits
        wsh = {{32{a[31]}}, a[31:0]};
        wsh = wsh >>> b[5:0];
        ovf = (a == smin) && (b == '1);
        q   = '0;
        m   = '0;
        if (b != '0 && !ovf) begin
            q = sa / sb;
            m = sa % sb;
        end
        case (r.op)
            op_add:    v = a + b;
            op_sub:    v = a - b;
            op_pass_a: v = a;
            op_pass_b: v = b;
            op_xor:    v = a ^ b;
            op_or:     v = a | b;
            op_and:    v = a & b;
            op_sll:    v = a << b[5:0];
            op_srl:    v = a >> b[5:0];
            op_sra:    v = r.word ? {32'b0, wsh[31:0]} : sh;
            op_slt:    v = {63'b0, sa < sb};
            op_sltu:   v = {63'b0, a < b};
            op_eq:     v = {63'b0, a == b};
            op_ge:     v = {63'b0, sa >= sb};
            op_geu:    v = {63'b0, a >= b};
            op_mul:    v = a * b;
            op_div:    v = (b == '0) ? '1 : ovf ? a : q;
            op_divu:   v = (b == '0) ? '1 : a / b;
            op_rem:    v = (b == '0) ? a : ovf ? '0 : m;
            op_remu:   v = (b == '0) ? a : a % b;
            default:   v = '0;
        endcase
        res_exp.value = v;
        res_exp.tag   = r.tag;
        return res_exp;
    endfunction

    // operands go to the selected fields, the rest stay random
    task automatic add_row(input alu_op_e op, input logic word, input src_a_e sel_a,
                           input src_b_e sel_b, input logic [63:0] x, input logic [63:0] y,
                           input logic rr = 1'b0, input logic fl = 1'b0);
        row_t row;
        row.req.pc    = (sel_a == src_a_pc) ? x : rand64();
        row.req.rs1   = (sel_a == src_a_rs1) ? x : rand64();
        row.req.rs2   = (sel_b == src_b_rs2) ? y : rand64();
        row.req.csr   = (sel_b == src_b_csr) ? y : rand64();
        row.req.imm   = (sel_b == src_b_imm) ? y : rand64();
        row.req.src_a = sel_a;
        row.req.src_b = sel_b;
        row.req.word  = word;
        row.req.op    = op;
        row.req.tag   = 4'(rows.size());
        row.rand_ready  = rr;
        row.flush_after = fl;
        rows.push_back(row);
    endtask

    task automatic check_result(input ex_result_t got, input ex_result_t exp, input int row);
        logic ok;
        ok = 1'b1;
        if (got.value !== exp.value) begin
            $display("mismatch res.value: got %h, expected %h", got.value, exp.value);
            ok = 1'b0;
        end
        if (got.tag !== exp.tag) begin
            $display("mismatch res.tag: got %h, expected %h", got.tag, exp.tag);
            ok = 1'b0;
        end
        if (ok) begin
            passed++;
        end else begin
            errors++;
        end
        $display("test %0d: tag %h %s", row, exp.tag, ok ? "ok" : "wrong result");
    endtask

    task automatic check_quiet(input logic valid);
        if (valid !== 1'b0) begin
            $display("a result came out right after the flush, older work was not dropped");
            errors++;
        end
    endtask

    initial begin
        logic [63:0] x;
        logic [63:0] r;
        int          idx;
        int          cycles;
        int          limit;
        logic        flush_next;
        logic        quiet_next;
        logic        timed_out;
        logic        rand_mode;
        rst       = 1'b1;
        flush     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        res_ready = 1'b0;

        // every single-cycle op, walking through the a and b selects
        for (int i = 0; i < 20; i++) begin
            if (alu_op_e'(i) != op_mul) begin
                add_row(alu_op_e'(i), 1'b0, src_a_e'(i % 2), src_b_e'(i % 3), rand64(), rand64());
            end
        end
        x = rand64();
        add_row(op_eq, 1'b0, src_a_rs1, src_b_rs2, x, x);
        add_row(op_ge, 1'b0, src_a_pc, src_b_csr, x, x);
        add_row(op_slt, 1'b0, src_a_rs1, src_b_rs2, 64'hffff_ffff_ffff_fff0, 64'd5);
        add_row(op_sltu, 1'b0, src_a_rs1, src_b_rs2, 64'hffff_ffff_ffff_fff0, 64'd5);
        add_row(op_ge, 1'b0, src_a_rs1, src_b_imm, 64'd5, 64'hffff_ffff_ffff_fff0);
        add_row(op_geu, 1'b0, src_a_rs1, src_b_imm, 64'd5, 64'hffff_ffff_ffff_fff0);
        // word mode
        add_row(op_pass_a, 1'b1, src_a_rs1, src_b_imm, 64'hdead_beef_8000_0001, 64'd0);
        add_row(op_add, 1'b1, src_a_rs1, src_b_rs2, 64'hffff_ffff_ffff_ffff, 64'd1);
        add_row(op_sra, 1'b1, src_a_rs1, src_b_imm, 64'h1234_5678_8000_0000, 64'd4);
        add_row(op_sra, 1'b1, src_a_pc, src_b_rs2, 64'h0000_0001_9000_0000, 64'd36);
        // divide by zero and the signed overflow case
        add_row(op_div, 1'b0, src_a_rs1, src_b_rs2, rand64(), 64'd0);
        add_row(op_divu, 1'b0, src_a_rs1, src_b_rs2, rand64(), 64'd0);
        add_row(op_rem, 1'b0, src_a_rs1, src_b_rs2, rand64(), 64'd0);
        add_row(op_remu, 1'b0, src_a_rs1, src_b_rs2, rand64(), 64'd0);
        add_row(op_div, 1'b0, src_a_rs1, src_b_csr, smin, '1);
        add_row(op_rem, 1'b0, src_a_rs1, src_b_csr, smin, '1);
        add_row(alu_op_e'(5'd27), 1'b0, src_a_rs1, src_b_rs2, rand64(), rand64());
        // multiplies with short ops queued behind them
        for (int i = 0; i < 3; i++) begin
            add_row(op_mul, 1'b0, src_a_rs1, src_b_rs2, rand64(), rand64(), i == 2);
            add_row(op_add, 1'b0, src_a_pc, src_b_imm, rand64(), rand64(), i == 2);
            add_row(op_xor, 1'b0, src_a_rs1, src_b_csr, rand64(), rand64(), i == 2);
        end
        for (int i = 0; i < 12; i++) begin
            x = rand64();
            add_row(alu_op_e'(x[7:0] % 20), x[8], src_a_e'(x[9]), src_b_e'(x[11:10] % 3),
                    rand64(), rand64(), 1'b1);
        end
        // flush lands while the multiply is running
        add_row(op_mul, 1'b0, src_a_rs1, src_b_rs2, rand64(), rand64());
        add_row(op_and, 1'b0, src_a_rs1, src_b_rs2, rand64(), rand64());
        add_row(op_sub, 1'b0, src_a_rs1, src_b_rs2, rand64(), rand64(), 1'b0, 1'b1);
        add_row(op_or, 1'b0, src_a_pc, src_b_imm, rand64(), rand64());
        add_row(op_mul, 1'b0, src_a_rs1, src_b_csr, rand64(), rand64());

        idx        = 0;
        cycles     = 0;
        flush_next = 1'b0;
        quiet_next = 1'b0;
        timed_out  = 1'b0;
        rand_mode  = 1'b0;
        limit      = rows.size() * (`EX_MUL_STEPS + 10);
        repeat (8) @(negedge clk);
        rst = 1'b0;

        while (!timed_out && (idx < rows.size() || exp_q.size() != 0)) begin
            @(negedge clk);
            r = rand64();
            if (idx < rows.size()) begin
                req       = rows[idx].req;
                rand_mode = rows[idx].rand_ready;
            end
            flush     = flush_next;
            req_valid = !flush_next && (idx < rows.size());
            res_ready = !flush_next && (!rand_mode || r[0]);
            #2;
            if (quiet_next) begin
                check_quiet(res_valid);
            end
            if (res_valid && res_ready) begin
                if (exp_q.size() == 0) begin
                    $display("result with tag %h arrived with nothing outstanding", res.tag);
                    errors++;
                end else begin
                    check_result(res, exp_q.pop_front(), row_q.pop_front());
                end
            end
            if (flush_next) begin
                while (exp_q.size() != 0) begin
                    $display("test %0d: dropped by flush", row_q.pop_front());
                    void'(exp_q.pop_front());
                    dropped++;
                end
            end
            quiet_next = flush_next;
            flush_next = 1'b0;
            if (req_valid && req_ready) begin
                exp_q.push_back(expected_result(rows[idx].req));
                row_q.push_back(idx);
                flush_next = rows[idx].flush_after;
                idx++;
            end
            cycles++;
            if (cycles > limit) begin
                timed_out = 1'b1;
            end
        end

        if (timed_out) begin
            $display("timeout: results still missing after %0d cycles", cycles);
        end
        $display("%0d passed, %0d errors, %0d dropped by flush", passed, errors, dropped);
        if (timed_out || errors != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule

//--- dv/ex_unit_checker.sv
module ex_unit_checker (
    input logic                      clk,
    input logic                      rst,
    input logic                      flush,
    input logic                      req_valid,
    input logic                      req_ready,
    input ex_issue_pkg::ex_issue_t   req,
    input logic                      res_valid,
    input logic                      res_ready,
    input ex_result_pkg::ex_result_t res
);

    // stalled request holds its payload
    assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready && !flush |=> $stable(req))
        else $error("issue request changed while stalled");

    assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready && !flush |=> res_valid && $stable(res))
        else $error("result changed or vanished while stalled");

    assert property (@(posedge clk) disable iff (rst) flush |=> !res_valid)
        else $error("result valid in the cycle after flush");

    assert property (@(posedge clk) rst && $past(rst) |-> !res_valid)
        else $error("result valid during reset");

endmodule

bind ex_unit ex_unit_checker checker_i (.*);

//--- design/ex_unit.sv
module ex_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  ex_issue_pkg::ex_issue_t   req,
    output logic                      res_valid,
    input  logic                      res_ready,
    output ex_result_pkg::ex_result_t res
);
    import ex_issue_pkg::*;

    logic     op_valid;
    logic     op_ready;
    ex_oper_t op;
    logic     fifo_valid;
    logic     fifo_ready;
    ex_oper_t fifo_data;

    ex_operand_mux mux_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_req    (req),
        .out_valid (op_valid),
        .out_ready (op_ready),
        .out_oper  (op)
    );

    ex_skid_fifo #(
        .payload_t (ex_oper_t)
    ) fifo_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push_valid (op_valid),
        .push_ready (op_ready),
        .push_data  (op),
        .pop_valid  (fifo_valid),
        .pop_ready  (fifo_ready),
        .pop_data   (fifo_data)
    );

    ex_alu alu_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (fifo_valid),
        .in_ready  (fifo_ready),
        .in_oper   (fifo_data),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .out_res   (res)
    );

endmodule

//--- design/ex_alu.sv
`include "ex_defs.svh"

module ex_alu (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  ex_issue_pkg::ex_oper_t     in_oper,
    output logic                       out_valid,
    input  logic                       out_ready,
    output ex_result_pkg::ex_result_t  out_res
);
    import ex_issue_pkg::*;

    localparam logic [`EX_XLEN-1:0] smin = {1'b1, {(`EX_XLEN-1){1'b0}}};

    logic [`EX_XLEN-1:0]  op_a;
    logic [`EX_XLEN-1:0]  op_b;
    logic [`EX_XLEN-1:0]  value;
    logic [31:0]          sra_word;
    logic [`EX_XLEN-1:0]  sra_dword;
    logic [`EX_XLEN-1:0]  quot_s;
    logic [`EX_XLEN-1:0]  rem_s;
    logic                 div_zero;
    logic                 div_ovf;
    logic                 accept;
    logic                 mul_start;
    logic                 mul_busy;
    logic                 mul_done;
    logic [`EX_XLEN-1:0]  mul_prod;
    logic [`EX_TAG_W-1:0] mul_tag;

    assign op_a      = in_oper.a;
    assign op_b      = in_oper.b;
    assign sra_word  = $signed(op_a[31:0]) >>> op_b[5:0];
    // signed shift and division results
    assign sra_dword = $signed(op_a) >>> op_b[5:0];
    assign quot_s    = $signed(op_a) / $signed(op_b);
    assign rem_s     = $signed(op_a) % $signed(op_b);
    assign div_zero  = (op_b == '0);
    assign div_ovf   = (op_a == smin) && (op_b == '1);

    // closed while a multiply runs or the result is still held
    assign in_ready  = !flush && !mul_busy && (!out_valid || out_ready);
    assign accept    = in_valid && in_ready;
    assign mul_start = accept && (in_oper.op == op_mul);

    always_comb begin
        case (in_oper.op)
            op_add:    value = op_a + op_b;
            op_sub:    value = op_a - op_b;
            op_pass_a: value = op_a;
            op_pass_b: value = op_b;
            op_xor:    value = op_a ^ op_b;
            op_or:     value = op_a | op_b;
            op_and:    value = op_a & op_b;
            op_sll:    value = op_a << op_b[5:0];
            op_srl:    value = op_a >> op_b[5:0];
            op_sra:    value = in_oper.word ? {32'b0, sra_word} : sra_dword;
            op_slt:    value = {63'b0, $signed(op_a) < $signed(op_b)};
            op_sltu:   value = {63'b0, op_a < op_b};
            op_eq:     value = {63'b0, op_a == op_b};
            op_ge:     value = {63'b0, $signed(op_a) >= $signed(op_b)};
            op_geu:    value = {63'b0, op_a >= op_b};
            op_div:    value = div_zero ? '1 : div_ovf ? op_a : quot_s;
            op_divu:   value = div_zero ? '1 : op_a / op_b;
            op_rem:    value = div_zero ? op_a : div_ovf ? '0 : rem_s;
            op_remu:   value = div_zero ? op_a : op_a % op_b;
            default:   value = '0;
        endcase
    end

    ex_mul_iter mul_i (
        .clk     (clk),
        .rst     (rst),
        .abort   (flush),
        .start   (mul_start),
        .a       (op_a),
        .b       (op_b),
        .busy    (mul_busy),
        .done    (mul_done),
        .product (mul_prod)
    );

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (mul_done || (accept && !mul_start)) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mul_tag <= in_oper.tag;
        end
        if (mul_done) begin
            out_res.value <= mul_prod;
            out_res.tag   <= mul_tag;
        end else if (accept && !mul_start) begin
            out_res.value <= value;
            out_res.tag   <= in_oper.tag;
        end
    end

endmodule

//--- design/ex_mul_iter.sv
`include "ex_defs.svh"

module ex_mul_iter (
    input  logic                clk,
    input  logic                rst,
    input  logic                abort,
    input  logic                start,
    input  logic [`EX_XLEN-1:0] a,
    input  logic [`EX_XLEN-1:0] b,
    output logic                busy,
    output logic                done,
    output logic [`EX_XLEN-1:0] product
);
    localparam int cnt_w = $clog2(`EX_MUL_STEPS + 1);

    logic [`EX_XLEN-1:0] mcand;
    logic [`EX_XLEN-1:0] mplier;
    logic [`EX_XLEN-1:0] acc;
    logic [cnt_w-1:0]    steps_left;

    // all steps done, product sits in acc for one cycle
    assign done    = busy && (steps_left == '0);
    assign product = acc;

    always_ff @(posedge clk) begin
        if (rst || abort) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand      <= a;
            mplier     <= b;
            acc        <= '0;
            steps_left <= cnt_w'(`EX_MUL_STEPS);
        end else if (busy && steps_left != '0) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            // bits shifted past the top only feed the high half
            mcand      <= mcand << 1;
            mplier     <= mplier >> 1;
            steps_left <= steps_left - 1'b1;
        end
    end

endmodule

//--- design/ex_skid_fifo.sv
`include "ex_defs.svh"

module ex_skid_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = `EX_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     push_valid,
    output logic     push_ready,
    input  payload_t push_data,
    output logic     pop_valid,
    input  logic     pop_ready,
    output payload_t pop_data
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign push_ready = (count != cnt_w'(depth));
    assign pop_valid  = (count != '0);
    assign pop_data   = mem[rd_ptr];

    assign do_push = push_valid && push_ready;
    assign do_pop  = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // wrap explicitly, depth need not be a power of two
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

//--- design/ex_operand_mux.sv
module ex_operand_mux (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  ex_issue_pkg::ex_issue_t in_req,
    output logic                    out_valid,
    input  logic                    out_ready,
    output ex_issue_pkg::ex_oper_t  out_oper
);
    import ex_issue_pkg::*;

    ex_oper_t prepared;
    logic     accept;

    // stage can take a new request when empty or being drained
    assign in_ready = !flush && (!out_valid || out_ready);
    assign accept   = in_valid && in_ready;

    always_comb begin
        prepared      = '0;
        prepared.word = in_req.word;
        prepared.op   = in_req.op;
        prepared.tag  = in_req.tag;
        if (in_req.src_a == src_a_rs1) begin
            // word mode only looks at the low half of rs1
            prepared.a = in_req.word ? {32'b0, in_req.rs1[31:0]} : in_req.rs1;
        end else begin
            prepared.a = in_req.pc;
        end
        case (in_req.src_b)
            src_b_rs2: prepared.b = in_req.rs2;
            src_b_csr: prepared.b = in_req.csr;
            default:   prepared.b = in_req.imm;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_oper <= prepared;
        end
    end

endmodule

//--- design/ex_result_pkg.sv
`include "ex_defs.svh"

package ex_result_pkg;

    // writeback value and the tag of the request that produced it
    typedef struct packed {
        logic [`EX_XLEN-1:0]  value;
        logic [`EX_TAG_W-1:0] tag;
    } ex_result_t;

endpackage

//--- design/ex_issue_pkg.sv
`include "ex_defs.svh"

package ex_issue_pkg;

    // codes 20..31 are unused and evaluate to zero
    typedef enum logic [4:0] {
        op_add, op_sub, op_pass_a, op_pass_b,
        op_xor, op_or, op_and,
        op_sll, op_srl, op_sra,
        op_slt, op_sltu, op_eq, op_ge, op_geu,
        op_mul, op_div, op_divu, op_rem, op_remu
    } alu_op_e;

    typedef enum logic {
        src_a_pc  = 1'b0,
        src_a_rs1 = 1'b1
    } src_a_e;

    typedef enum logic [1:0] {
        src_b_imm = 2'd0,
        src_b_rs2 = 2'd1,
        src_b_csr = 2'd2
    } src_b_e;

    typedef struct packed {
        logic [`EX_XLEN-1:0]  pc;
        logic [`EX_XLEN-1:0]  rs1;
        logic [`EX_XLEN-1:0]  rs2;
        logic [`EX_XLEN-1:0]  csr;
        logic [`EX_XLEN-1:0]  imm;
        src_a_e               src_a;
        src_b_e               src_b;
        logic                 word;
        alu_op_e              op;
        logic [`EX_TAG_W-1:0] tag;
    } ex_issue_t;

    // operands already selected, ready for the ALU
    typedef struct packed {
        logic [`EX_XLEN-1:0]  a;
        logic [`EX_XLEN-1:0]  b;
        logic                 word;
        alu_op_e              op;
        logic [`EX_TAG_W-1:0] tag;
    } ex_oper_t;

endpackage

//--- design/ex_defs.svh
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// datapath width, RV64
`define EX_XLEN 64

// issue tag carried through to the result port
`define EX_TAG_W 4

// entries between operand mux and ALU
`define EX_FIFO_DEPTH 4

// one multiplier bit per step
`define EX_MUL_STEPS 64

`endif
